// File: tb/bp_input.txt
# rst fetch_pc r_valid r_pc r_op r_taken r_target r_index | exp_taken exp_next_pc exp_index name
# All fields hex, one line per clock cycle, a resolve updates state for the next line
0 00000000 0 00000000 00 0 00000000 00 0 00000004 00 cold_zero
0 00001010 0 00000000 00 0 00000000 00 0 00001014 04 cold_jump
0 fffffffc 0 00000000 00 0 00000000 00 0 00000000 1f cold_wrap
0 00001020 0 00000000 00 0 00000000 00 0 00001024 08 cold_branch
0 00001010 1 00001010 6f 1 00002000 04 0 00001014 04 jal_same_cycle
0 00001010 1 00001010 6f 1 00002000 04 1 00002000 04 jal_hit
0 00001020 1 00001020 13 1 00001100 08 0 00001024 08 jal_no_history
0 00001060 1 00001060 63 1 00001300 18 0 00001064 18 warm_p0
0 00001060 1 00001060 63 1 00001300 08 0 00001064 08 warm_p1
0 00001060 1 00001060 63 1 00001300 00 0 00001064 00 warm_p2
0 00001060 1 00001060 63 1 00001300 04 0 00001064 04 warm_p3
0 00001060 1 00001060 63 1 00001300 06 0 00001064 06 warm_p4
0 00001060 0 00000000 00 0 00000000 00 0 00001064 07 warm_full
0 00001020 1 00001020 63 1 00001100 17 0 00001024 17 br_first_miss
0 00001020 1 00001020 63 1 00001100 17 0 00001024 17 br_weak
0 00001020 1 00001020 63 1 00001100 17 1 00001100 17 br_taken
0 00001020 1 00001020 63 1 00001100 17 1 00001100 17 br_sat1
0 00001020 1 00001020 63 1 00001100 17 1 00001100 17 br_sat2
0 00001020 1 00001020 63 0 00001100 17 1 00001100 17 br_sat3
0 00001060 0 00000000 00 0 00000000 00 1 00001300 17 sat_keep_taken
0 00001020 0 00000000 00 0 00000000 00 0 00001024 07 hist_new_index
0 00002020 1 00002020 6f 1 00004000 07 0 00002024 07 alias_miss
0 00002020 0 00000000 00 0 00000000 00 1 00004000 07 alias_hit
0 00001020 0 00000000 00 0 00000000 00 0 00001024 07 alias_evicted
0 00001040 1 00001040 67 1 00003000 1f 0 00001044 1f jalr_miss
0 00001040 1 00001040 67 1 00003400 1f 1 00003000 1f jalr_old_target
0 00001040 0 00000000 00 0 00000000 00 1 00003400 1f jalr_new_target
0 00001010 0 00000000 00 0 00000000 00 1 00002000 0b jal_still_hit
1 00000000 0 00000000 00 0 00000000 00 0 00000004 00 mid_reset0
1 00000000 0 00000000 00 0 00000000 00 0 00000004 00 mid_reset1
0 00001060 0 00000000 00 0 00000000 00 0 00001064 18 rst_branch_p
0 00001040 0 00000000 00 0 00000000 00 0 00001044 10 rst_jalr
0 00001010 0 00000000 00 0 00000000 00 0 00001014 04 rst_jump
0 00001020 0 00000000 00 0 00000000 00 0 00001024 08 rst_branch_b

// File: tb.f
hw/bp_pkg.sv
hw/bp_update_if.sv
hw/branch_target_buffer.sv
hw/gshare_predictor.sv
hw/bp_control.sv
hw/branch_predictor_top.sv
tb/bp_checker.sv
tb/tb_top.sv

// File: Makefile
# Verilator build and run for the branch prediction unit testbench

VERILATOR ?= verilator
TOP       ?= tb_top
LOG       ?= sim.log
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))
DATA := tb/bp_input.txt

.PHONY: all build run check clean

all: check

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN) $(DATA)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status

check: run
	@if grep -q "Errors found" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb/tb_top.sv
// Testbench top, replays per-cycle vectors from tb/bp_input.txt into the prediction unit
`timescale 1ns/1ps

module tb_top;

    localparam int    NUM_BTB_ENTRIES = 32;
    localparam int    NUM_GHR_BITS    = 5;
    localparam int    RESET_CYCLES    = 4;
    localparam int    MAX_VECTORS     = 200;
    localparam int    DRAIN_LIMIT     = 16;
    localparam int    NAME_CHARS      = 24;
    localparam string DATA_FILE       = "tb/bp_input.txt";

    // DUT ports
    logic                    clk = 1'b0;
    logic                    reset_i;
    logic [31:0]             fetch_pc_i;
    logic                    resolve_valid_i;
    logic [31:0]             resolve_pc_i;
    logic [6:0]              resolve_op_i;
    logic                    resolve_taken_i;
    logic [31:0]             resolve_target_i;
    logic [NUM_GHR_BITS-1:0] resolve_pht_index_i;
    logic                    predict_taken_o;
    logic [31:0]             predict_next_pc_o;
    logic [NUM_GHR_BITS-1:0] predict_pht_index_o;

    // Expected side, lined up with the stimulus of the same cycle
    logic                    check_en;
    logic [8*NAME_CHARS-1:0] test_name;
    logic                    exp_taken;
    logic [31:0]             exp_next_pc;
    logic [NUM_GHR_BITS-1:0] exp_index;
    int                      check_count;
    int                      error_count;

    // One vector as read from the file
    logic                    v_rst;
    logic [31:0]             v_fetch_pc;
    logic                    v_resolve_valid;
    logic [31:0]             v_resolve_pc;
    logic [6:0]              v_resolve_op;
    logic                    v_resolve_taken;
    logic [31:0]             v_resolve_target;
    logic [NUM_GHR_BITS-1:0] v_resolve_index;
    logic                    v_exp_taken;
    logic [31:0]             v_exp_next_pc;
    logic [NUM_GHR_BITS-1:0] v_exp_index;
    logic [8*NAME_CHARS-1:0] v_name;

    int fd;
    int other_errors;
    int vectors_checked;
    bit timed_out;

    // 8 ns clock
    always #4 clk = ~clk;

    branch_predictor_top #(
        .NUM_BTB_ENTRIES(NUM_BTB_ENTRIES),
        .NUM_GHR_BITS(NUM_GHR_BITS)
    ) i_dut (
        .clk, .reset_i, .fetch_pc_i,
        .resolve_valid_i, .resolve_pc_i, .resolve_op_i, .resolve_taken_i,
        .resolve_target_i, .resolve_pht_index_i,
        .predict_taken_o, .predict_next_pc_o, .predict_pht_index_o
    );

    bp_checker #(
        .NUM_GHR_BITS(NUM_GHR_BITS),
        .NAME_CHARS(NAME_CHARS)
    ) i_checker (
        .clk, .check_en_i(check_en), .test_name_i(test_name),
        .fetch_pc_i, .exp_taken_i(exp_taken), .exp_next_pc_i(exp_next_pc),
        .exp_index_i(exp_index), .predict_taken_i(predict_taken_o),
        .predict_next_pc_i(predict_next_pc_o), .predict_pht_index_i(predict_pht_index_o),
        .check_count_o(check_count), .error_count_o(error_count)
    );

    // Next data line, comment and blank lines skipped
    task automatic read_vector(output bit got);
        string line;
        int    n;
        got = 1'b0;
        while (!got && !$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            // 8'h23 is '#', 8'h0a an empty line
            if (n > 0 && line.getc(0) != 8'h23 && line.getc(0) != 8'h0a) begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %s",
                            v_rst, v_fetch_pc, v_resolve_valid, v_resolve_pc,
                            v_resolve_op, v_resolve_taken, v_resolve_target,
                            v_resolve_index, v_exp_taken, v_exp_next_pc,
                            v_exp_index, v_name);
                if (n == 12) begin
                    got = 1'b1;
                end else begin
                    $display("Malformed line in stimulus file: %s", line);
                    other_errors++;
                end
            end
        end
    endtask

    // Inputs and expected values change together on the rising edge
    task automatic drive_vector();
        reset_i             <= v_rst;
        fetch_pc_i          <= v_fetch_pc;
        resolve_valid_i     <= v_resolve_valid;
        resolve_pc_i        <= v_resolve_pc;
        resolve_op_i        <= v_resolve_op;
        resolve_taken_i     <= v_resolve_taken;
        resolve_target_i    <= v_resolve_target;
        resolve_pht_index_i <= v_resolve_index;
        exp_taken           <= v_exp_taken;
        exp_next_pc         <= v_exp_next_pc;
        exp_index           <= v_exp_index;
        test_name           <= v_name;
        // Lookups during a reset cycle are not compared
        check_en            <= !v_rst;
        if (!v_rst) begin
            vectors_checked++;
        end
    endtask

    task automatic hold_reset();
        int cycles;
        cycles = 0;
        while (cycles < RESET_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        reset_i <= 1'b0;
    endtask

    task automatic apply_vectors();
        bit got;
        int count;
        got   = 1'b1;
        count = 0;
        while (got && !timed_out) begin
            @(posedge clk);
            read_vector(got);
            if (got) begin
                drive_vector();
                count++;
                if (count >= MAX_VECTORS) begin
                    $display("Timeout: stimulus file did not end within %0d vectors",
                             MAX_VECTORS);
                    other_errors++;
                    timed_out = 1'b1;
                end
            end else begin
                // Quiet bus once the file is done
                resolve_valid_i <= 1'b0;
                check_en        <= 1'b0;
            end
        end
    endtask

    // Let the checker catch up with the last driven vector
    task automatic drain_checker();
        int waited;
        waited = 0;
        while (check_count != vectors_checked && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (check_count != vectors_checked) begin
            $display("Timeout: checker compared %0d of %0d vectors",
                     check_count, vectors_checked);
            other_errors++;
        end
    endtask

    task automatic finish_run();
        $display("Summary: %0d vectors checked, %0d mismatches, %0d other failures",
                 check_count, error_count, other_errors);
        if (error_count + other_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    endtask

    initial begin
        reset_i             = 1'b1;
        fetch_pc_i          = '0;
        resolve_valid_i     = 1'b0;
        resolve_pc_i        = '0;
        resolve_op_i        = '0;
        resolve_taken_i     = 1'b0;
        resolve_target_i    = '0;
        resolve_pht_index_i = '0;
        check_en            = 1'b0;
        test_name           = '0;
        exp_taken           = 1'b0;
        exp_next_pc         = '0;
        exp_index           = '0;
        other_errors        = 0;
        vectors_checked     = 0;
        timed_out           = 1'b0;
        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open stimulus file %s", DATA_FILE);
            other_errors++;
        end else begin
            hold_reset();
            apply_vectors();
            if (!timed_out) begin
                drain_checker();
            end
            $fclose(fd);
        end
        finish_run();
    end

endmodule

// File: tb/bp_checker.sv
// Checks DUT predictions against the expected columns each cycle under tb_top
`timescale 1ns/1ps

module bp_checker #(
    parameter int NUM_GHR_BITS = 5,
    parameter int NAME_CHARS   = 24
) (
    input  logic                    clk,
    input  logic                    check_en_i,
    input  logic [8*NAME_CHARS-1:0] test_name_i,
    input  logic [31:0]             fetch_pc_i,

    // Expected columns
    input  logic                    exp_taken_i,
    input  logic [31:0]             exp_next_pc_i,
    input  logic [NUM_GHR_BITS-1:0] exp_index_i,

    // Observed DUT outputs
    input  logic                    predict_taken_i,
    input  logic [31:0]             predict_next_pc_i,
    input  logic [NUM_GHR_BITS-1:0] predict_pht_index_i,

    output int                      check_count_o,
    output int                      error_count_o
);

    int checks = 0;
    int errors = 0;

    assign check_count_o = checks;
    assign error_count_o = errors;

    // Mismatch report carries the fetch PC to locate the vector
    task automatic compare_field(input string field, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("FAIL %0s %0s at pc %h expected %h actual %h",
                     test_name_i, field, fetch_pc_i, expected, actual);
        end
    endtask

    // Sampled mid-cycle when inputs and state have settled since the last edge
    always @(negedge clk) begin
        if (check_en_i) begin
            checks++;
            compare_field("taken", 32'(exp_taken_i), 32'(predict_taken_i));
            compare_field("next_pc", exp_next_pc_i, predict_next_pc_i);
            compare_field("pht_index", 32'(exp_index_i), 32'(predict_pht_index_i));
        end
    end

endmodule

// File: hw/branch_predictor_top.sv
// Top level of the fetch-stage branch prediction unit, plain ports for fetch and execute
`timescale 1ns/1ps

module branch_predictor_top #(
    parameter int NUM_BTB_ENTRIES = 32,
    parameter int NUM_GHR_BITS    = 5
) (
    input  logic                    clk,
    input  logic                    reset_i,

    // Fetch lookup
    input  logic [31:0]             fetch_pc_i,

    // Resolve strobe from execute
    input  logic                    resolve_valid_i,
    input  logic [31:0]             resolve_pc_i,
    input  logic [6:0]              resolve_op_i,
    input  logic                    resolve_taken_i,
    input  logic [31:0]             resolve_target_i,
    input  logic [NUM_GHR_BITS-1:0] resolve_pht_index_i,

    // Prediction, valid in the same cycle as fetch_pc_i
    output logic                    predict_taken_o,
    output logic [31:0]             predict_next_pc_o,
    output logic [NUM_GHR_BITS-1:0] predict_pht_index_o
);

    // Fetch side results
    logic                    btb_hit;
    bp_pkg::bp_kind_e        btb_kind;
    logic [31:0]             btb_target;
    logic                    pht_msb;

    // Training from control to gshare
    logic                    train_en;
    logic                    train_taken;
    logic [NUM_GHR_BITS-1:0] train_index;
    logic                    hist_shift;

    bp_update_if #(.NUM_BTB_ENTRIES(NUM_BTB_ENTRIES)) upd_if ();

    branch_target_buffer #(.NUM_BTB_ENTRIES(NUM_BTB_ENTRIES)) i_btb (
        .clk, .reset_i,
        .lookup_pc_i(fetch_pc_i), .lookup_hit_o(btb_hit),
        .lookup_kind_o(btb_kind), .lookup_target_o(btb_target),
        .upd(upd_if.buffer)
    );

    gshare_predictor #(.NUM_GHR_BITS(NUM_GHR_BITS)) i_gshare (
        .clk, .reset_i,
        .lookup_pc_i(fetch_pc_i), .predict_msb_o(pht_msb),
        .pht_index_o(predict_pht_index_o),
        .train_en_i(train_en), .train_taken_i(train_taken),
        .train_index_i(train_index), .hist_shift_i(hist_shift)
    );

    bp_control #(.NUM_GHR_BITS(NUM_GHR_BITS)) i_control (
        .fetch_pc_i, .btb_hit_i(btb_hit), .btb_kind_i(btb_kind),
        .btb_target_i(btb_target), .pht_msb_i(pht_msb),
        .resolve_valid_i, .resolve_pc_i, .resolve_op_i, .resolve_taken_i,
        .resolve_target_i, .resolve_pht_index_i,
        .upd(upd_if.control),
        .train_en_o(train_en), .train_taken_o(train_taken),
        .train_index_o(train_index), .hist_shift_o(hist_shift),
        .predict_taken_o, .predict_next_pc_o
    );

endmodule

// File: hw/bp_control.sv
// Control for the prediction unit, decodes resolves into updates and forms the fetch prediction
`timescale 1ns/1ps

module bp_control #(
    parameter int NUM_GHR_BITS = 5
) (
    // Fetch side results from the two tables
    input  logic [bp_pkg::XLEN-1:0]     fetch_pc_i,
    input  logic                        btb_hit_i,
    input  bp_pkg::bp_kind_e            btb_kind_i,
    input  logic [bp_pkg::XLEN-1:0]     btb_target_i,
    input  logic                        pht_msb_i,

    // Resolve strobe from execute
    input  logic                        resolve_valid_i,
    input  logic [bp_pkg::XLEN-1:0]     resolve_pc_i,
    input  logic [bp_pkg::OPCODE_W-1:0] resolve_op_i,
    input  logic                        resolve_taken_i,
    input  logic [bp_pkg::XLEN-1:0]     resolve_target_i,
    input  logic [NUM_GHR_BITS-1:0]     resolve_pht_index_i,

    // Buffer probe and write
    bp_update_if.control                upd,

    // Counter and history training
    output logic                        train_en_o,
    output logic                        train_taken_o,
    output logic [NUM_GHR_BITS-1:0]     train_index_o,
    output logic                        hist_shift_o,

    // Prediction back to fetch
    output logic                        predict_taken_o,
    output logic [bp_pkg::XLEN-1:0]     predict_next_pc_o
);

    bp_pkg::bp_kind_e resolve_kind;
    logic             resolve_is_cti;
    logic             resolve_is_branch;
    logic [bp_pkg::XLEN-1:0] fallthrough_pc;

    // Opcode decode
    // jal and jalr share one kind, both are always taken
    always_comb begin
        case (resolve_op_i)
            bp_pkg::OP_JAL,
            bp_pkg::OP_JALR:   resolve_kind = bp_pkg::KIND_JUMP;
            bp_pkg::OP_BRANCH: resolve_kind = bp_pkg::KIND_BRANCH;
            default:           resolve_kind = bp_pkg::KIND_NONE;
        endcase
    end

    assign resolve_is_cti    = resolve_valid_i && (resolve_kind != bp_pkg::KIND_NONE);
    assign resolve_is_branch = resolve_valid_i && (resolve_kind == bp_pkg::KIND_BRANCH);

    // Buffer update
    // Write on a new PC or on a changed target, a matching entry is left alone
    assign upd.probe_pc  = resolve_pc_i;
    assign upd.wr_target = resolve_target_i;
    assign upd.wr_kind   = resolve_kind;
    assign upd.wr_en     = resolve_is_cti && (!upd.probe_hit || !upd.probe_same_target);

    // Training
    // Only conditional branches touch counters and history
    assign train_en_o    = resolve_is_branch;
    assign train_taken_o = resolve_taken_i;
    assign train_index_o = resolve_pht_index_i;
    assign hist_shift_o  = resolve_is_branch;

    // Fetch prediction
    assign fallthrough_pc = fetch_pc_i + bp_pkg::INSTR_BYTES;

    always_comb begin
        predict_taken_o   = 1'b0;
        predict_next_pc_o = fallthrough_pc;
        if (btb_hit_i) begin
            case (btb_kind_i)
                bp_pkg::KIND_JUMP: begin
                    predict_taken_o   = 1'b1;
                    predict_next_pc_o = btb_target_i;
                end
                bp_pkg::KIND_BRANCH: begin
                    // Direction from the counter, target only when taken
                    predict_taken_o = pht_msb_i;
                    if (pht_msb_i) begin
                        predict_next_pc_o = btb_target_i;
                    end
                end
                default: begin
                    predict_taken_o = 1'b0;
                end
            endcase
        end
    end

endmodule

// File: hw/gshare_predictor.sv
// Gshare direction predictor, history register and 2-bit counter table indexed by pc xor history
`timescale 1ns/1ps

module gshare_predictor #(
    parameter int NUM_GHR_BITS = 5
) (
    input  logic                    clk,
    input  logic                    reset_i,

    // Fetch side read
    input  logic [bp_pkg::XLEN-1:0] lookup_pc_i,
    output logic                    predict_msb_o,
    output logic [NUM_GHR_BITS-1:0] pht_index_o,

    // Resolve side training
    input  logic                    train_en_i,
    input  logic                    train_taken_i,
    input  logic [NUM_GHR_BITS-1:0] train_index_i,
    input  logic                    hist_shift_i
);

    localparam int NUM_COUNTERS = 1 << NUM_GHR_BITS;

    // Global history, newest outcome in the top bit
    logic [NUM_GHR_BITS-1:0] ghr_q;

    // Pattern history table of saturating counters
    logic [1:0] pht_q [NUM_COUNTERS];

    // Hash of the word address bits with the history
    assign pht_index_o =
        lookup_pc_i[NUM_GHR_BITS+bp_pkg::PC_ALIGN_BITS-1:bp_pkg::PC_ALIGN_BITS] ^ ghr_q;

    // Upper counter bit is the direction, 2 and 3 mean taken
    assign predict_msb_o = pht_q[pht_index_o][1];

    // Counter training
    // Training uses the index captured at fetch, not a fresh hash
    always_ff @(posedge clk) begin
        if (reset_i) begin
            // Everything starts strongly not taken
            for (int i = 0; i < NUM_COUNTERS; i++) begin
                pht_q[i] <= bp_pkg::CNT_MIN;
            end
        end else if (train_en_i) begin
            if (train_taken_i) begin
                if (pht_q[train_index_i] != bp_pkg::CNT_MAX) begin
                    pht_q[train_index_i] <= pht_q[train_index_i] + 2'd1;
                end
            end else begin
                if (pht_q[train_index_i] != bp_pkg::CNT_MIN) begin
                    pht_q[train_index_i] <= pht_q[train_index_i] - 2'd1;
                end
            end
        end
    end

    // History shift
    // Outcome enters at the top, oldest bit drops off the bottom
    always_ff @(posedge clk) begin
        if (reset_i) begin
            ghr_q <= '0;
        end else if (hist_shift_i) begin
            ghr_q <= {train_taken_i, ghr_q[NUM_GHR_BITS-1:1]};
        end
    end

endmodule

// File: hw/branch_target_buffer.sv
// Direct-mapped target buffer, combinational fetch lookup plus resolve probe and edge write
`timescale 1ns/1ps

module branch_target_buffer #(
    parameter int NUM_BTB_ENTRIES = 32
) (
    input  logic                    clk,
    input  logic                    reset_i,

    // Fetch lookup
    input  logic [bp_pkg::XLEN-1:0] lookup_pc_i,
    output logic                    lookup_hit_o,
    output bp_pkg::bp_kind_e        lookup_kind_o,
    output logic [bp_pkg::XLEN-1:0] lookup_target_o,

    // Resolve probe and write
    bp_update_if.buffer             upd
);

    localparam int IDX_BITS = $clog2(NUM_BTB_ENTRIES);
    localparam int TAG_BITS = bp_pkg::XLEN - IDX_BITS - bp_pkg::PC_ALIGN_BITS;

    // Entry storage
    // Only the valid bits carry control meaning, the rest is payload
    logic [NUM_BTB_ENTRIES-1:0] valid_q;
    logic [TAG_BITS-1:0]        tag_q    [NUM_BTB_ENTRIES];
    logic [bp_pkg::XLEN-1:0]    target_q [NUM_BTB_ENTRIES];
    bp_pkg::bp_kind_e           kind_q   [NUM_BTB_ENTRIES];

    // Fetch side address split
    logic [IDX_BITS-1:0] lookup_idx;
    logic [TAG_BITS-1:0] lookup_tag;

    // Resolve side address split
    logic [IDX_BITS-1:0] probe_idx;
    logic [TAG_BITS-1:0] probe_tag;

    assign lookup_idx = upd.pc_index(lookup_pc_i);
    assign lookup_tag = upd.pc_tag(lookup_pc_i);
    assign probe_idx  = upd.pc_index(upd.probe_pc);
    assign probe_tag  = upd.pc_tag(upd.probe_pc);

    // Fetch lookup
    // A miss reports no kind so control falls through to pc+4
    always_comb begin
        lookup_hit_o    = valid_q[lookup_idx] && (tag_q[lookup_idx] == lookup_tag);
        lookup_target_o = target_q[lookup_idx];
        if (lookup_hit_o) begin
            lookup_kind_o = kind_q[lookup_idx];
        end else begin
            lookup_kind_o = bp_pkg::KIND_NONE;
        end
    end

    // Resolve probe
    // Tells control whether the resolved PC is already learned with this target
    assign upd.probe_hit = valid_q[probe_idx] && (tag_q[probe_idx] == probe_tag);
    assign upd.probe_same_target = (target_q[probe_idx] == upd.wr_target);

    // Valid bits, cleared by reset and set by any write
    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= '0;
        end else if (upd.wr_en) begin
            valid_q[probe_idx] <= 1'b1;
        end
    end

    // Entry payload
    // A write simply evicts whatever sits at the index, no replacement choice
    always_ff @(posedge clk) begin
        if (upd.wr_en) begin
            tag_q[probe_idx]    <= probe_tag;
            target_q[probe_idx] <= upd.wr_target;
            kind_q[probe_idx]   <= upd.wr_kind;
        end
    end

endmodule

// File: hw/bp_update_if.sv
// Resolve-side traffic between the control block and the target buffer, probe and write
`timescale 1ns/1ps

interface bp_update_if #(
    parameter int NUM_BTB_ENTRIES = 32
);

    localparam int IDX_BITS = $clog2(NUM_BTB_ENTRIES);
    localparam int TAG_BITS = bp_pkg::XLEN - IDX_BITS - bp_pkg::PC_ALIGN_BITS;

    // Control side drives the probe address and the write request
    logic [bp_pkg::XLEN-1:0] probe_pc;
    logic                    wr_en;
    logic [bp_pkg::XLEN-1:0] wr_target;
    bp_pkg::bp_kind_e        wr_kind;

    // Buffer answers with the state of the probed entry
    logic probe_hit;
    logic probe_same_target;

    // Entry index, taken just above the word offset
    function automatic logic [IDX_BITS-1:0] pc_index(input logic [bp_pkg::XLEN-1:0] pc);
        return pc[IDX_BITS+bp_pkg::PC_ALIGN_BITS-1:bp_pkg::PC_ALIGN_BITS];
    endfunction

    // Tag is every PC bit above the index
    function automatic logic [TAG_BITS-1:0] pc_tag(input logic [bp_pkg::XLEN-1:0] pc);
        return pc[bp_pkg::XLEN-1:IDX_BITS+bp_pkg::PC_ALIGN_BITS];
    endfunction

    modport control (
        output probe_pc, wr_en, wr_target, wr_kind,
        input  probe_hit, probe_same_target
    );

    modport buffer (
        input  probe_pc, wr_en, wr_target, wr_kind,
        output probe_hit, probe_same_target,
        import pc_index, pc_tag
    );

endinterface

// File: hw/bp_pkg.sv
// Shared opcode constants, branch kind encoding and widths for the branch prediction unit
package bp_pkg;

    // Machine word width, used for every PC and target
    localparam int XLEN = 32;

    // Width of the major opcode field of a resolved instruction
    localparam int OPCODE_W = 7;

    // Instructions are word aligned, so the two low PC bits never index a table
    localparam int PC_ALIGN_BITS = 2;

    // Fallthrough step from one fetch address to the next
    localparam logic [XLEN-1:0] INSTR_BYTES = 32'd4;

    // Opcodes of the control transfer instructions that the unit learns
    // Unconditional jump with PC-relative target
    localparam logic [OPCODE_W-1:0] OP_JAL = 7'b1101111;
    // Register-indirect jump, target can change between executions
    localparam logic [OPCODE_W-1:0] OP_JALR = 7'b1100111;
    // Conditional branch family (beq, bne, blt and so on)
    localparam logic [OPCODE_W-1:0] OP_BRANCH = 7'b1100011;

    // Kind of control transfer held in a target buffer entry
    // KIND_NONE also marks a lookup that missed
    typedef enum logic [1:0] {
        KIND_NONE   = 2'd0,
        KIND_BRANCH = 2'd1,
        KIND_JUMP   = 2'd2
    } bp_kind_e;

    // Two-bit saturating counter limits
    localparam logic [1:0] CNT_MIN = 2'b00;
    localparam logic [1:0] CNT_MAX = 2'b11;

endpackage
